// File: sprite_defines.svh
`ifndef SPRITE_DEFINES_SVH
`define SPRITE_DEFINES_SVH

// number of hardware sprites in the bank
`define SPR_NUM 8

// one sprite line is three bytes wide
`define SPR_DATA_BITS 24

// width of the byte delivered by each load strobe
`define SPR_BYTE_BITS 8

// beam x position and sprite x register width
`define SPR_X_BITS 9

// a sprite pixel is two bits, the upper one marks a foreground dot
`define SPR_PIX_BITS 2

// loads that must land on an enabled sprite before it is armed
`define SPR_LOADS 3

`endif

// File: sprite_pkg.sv
`include "sprite_defines.svh"

package sprite_pkg;

    // sprite number, wide enough to address every sprite
    typedef logic [$clog2(`SPR_NUM)-1:0] spr_idx_t;

    // one bit per sprite, used for enables and collision vectors
    typedef logic [`SPR_NUM-1:0] spr_mask_t;

    typedef logic [`SPR_PIX_BITS-1:0] spr_pix_t;

    // sprite 0 sits in the lowest slot
    typedef spr_pix_t [`SPR_NUM-1:0] spr_pix_vec_t;

    typedef logic [`SPR_X_BITS-1:0] spr_x_t;

    // static sprite register file as seen by the sequencer
    typedef struct packed {
        spr_mask_t            en;
        spr_mask_t            xe;
        spr_mask_t            mmc;
        spr_x_t [`SPR_NUM-1:0] x;
    } spr_cfg_t;

    // one data byte aimed at a single sprite
    typedef struct packed {
        logic                     valid;
        spr_idx_t                 idx;
        logic [`SPR_BYTE_BITS-1:0] data;
    } spr_load_t;

    // dot tick strobe plus the beam levels that hold between ticks
    typedef struct packed {
        logic   dot_tick;
        spr_x_t xpos;
        logic   background;
        logic   border;
    } beam_t;

    typedef enum logic [1:0] {
        SPR_IDLE,
        SPR_LOADING,
        SPR_ARMED,
        SPR_SHIFTING
    } spr_state_e;

endpackage

// File: sprite_shifter_bank.sv
`timescale 1ns/1ns

`include "sprite_defines.svh"

module sprite_shifter_bank (
    input  logic                    clk_dot4x,
    input  logic                    rst,
    input  sprite_pkg::spr_cfg_t    cfg_i,
    input  sprite_pkg::spr_load_t   load_i,
    input  sprite_pkg::beam_t       beam_i,
    output sprite_pkg::spr_pix_vec_t pix_o
);

    // counts loads up to the one that arms the sprite
    localparam int LOAD_W = $clog2(`SPR_LOADS);
    // counts shifts left in the window, one per data bit
    localparam int REM_W = $clog2(`SPR_DATA_BITS + 1);
    localparam logic [LOAD_W-1:0] LOAD_LAST = LOAD_W'(`SPR_LOADS - 1);
    localparam logic [REM_W-1:0] REM_FULL = REM_W'(`SPR_DATA_BITS);

    for (genvar n = 0; n < `SPR_NUM; n++) begin : g_spr
        sprite_pkg::spr_state_e       state_q;
        logic [`SPR_DATA_BITS-1:0]    shreg_q;
        logic [LOAD_W-1:0]            load_cnt_q;
        logic [REM_W-1:0]             rem_q;
        logic                         xe_ff_q;
        logic                         mc_ph_q;
        sprite_pkg::spr_pix_t         pix_q;
        logic                         load_hit;
        logic                         start;
        logic                         run;
        logic                         xe_ff_cur;
        logic                         mc_ph_cur;
        logic                         shift_now;
        logic [REM_W-1:0]             rem_base;

        // loads only count while the sprite is not yet armed
        assign load_hit = load_i.valid && load_i.idx == sprite_pkg::spr_idx_t'(n)
                          && cfg_i.en[n]
                          && (state_q == sprite_pkg::SPR_IDLE
                              || state_q == sprite_pkg::SPR_LOADING);

        // the tick that sees the x match is offset 0 and already emits a pixel
        assign start = beam_i.dot_tick && state_q == sprite_pkg::SPR_ARMED
                       && beam_i.xpos == cfg_i.x[n];
        assign run = beam_i.dot_tick && state_q == sprite_pkg::SPR_SHIFTING
                     && rem_q != '0;

        // a new window always begins on the first half of an expanded bit
        // and on a fresh multicolor pair
        assign xe_ff_cur = start ? 1'b0 : xe_ff_q;
        assign mc_ph_cur = start ? 1'b0 : mc_ph_q;

        // without expansion every tick moves to the next bit,
        // with it only the second tick of each bit does
        assign shift_now = !cfg_i.xe[n] || xe_ff_cur;
        assign rem_base = start ? REM_FULL : rem_q;

        always_ff @(posedge clk_dot4x) begin
            if (rst) begin
                state_q    <= sprite_pkg::SPR_IDLE;
                load_cnt_q <= '0;
                rem_q      <= '0;
                xe_ff_q    <= 1'b0;
                mc_ph_q    <= 1'b0;
                pix_q      <= '0;
            end else begin
                if (load_hit) begin
                    if (load_cnt_q == LOAD_LAST) begin
                        state_q    <= sprite_pkg::SPR_ARMED;
                        load_cnt_q <= '0;
                    end else begin
                        state_q    <= sprite_pkg::SPR_LOADING;
                        load_cnt_q <= load_cnt_q + 1'b1;
                    end
                end
                if (start || run) begin
                    state_q <= sprite_pkg::SPR_SHIFTING;
                    xe_ff_q <= cfg_i.xe[n] && !xe_ff_cur;
                    // the pair phase follows the bit shifts, not the ticks
                    mc_ph_q <= shift_now ? !mc_ph_cur : mc_ph_cur;
                    rem_q   <= rem_base - REM_W'(shift_now);
                    if (cfg_i.mmc[n]) begin
                        // a multicolor pair covers two bit slots, so the odd
                        // slot keeps showing the pair picked on the even one
                        if (!mc_ph_cur) begin
                            pix_q <= shreg_q[`SPR_DATA_BITS-1 -: `SPR_PIX_BITS];
                        end
                    end else begin
                        pix_q <= {shreg_q[`SPR_DATA_BITS-1], 1'b0};
                    end
                end else if (beam_i.dot_tick && state_q == sprite_pkg::SPR_SHIFTING) begin
                    // all bits are out, the sprite wants three new loads
                    state_q <= sprite_pkg::SPR_IDLE;
                    pix_q   <= '0;
                end
            end
        end

        // line data enters at the bottom and leaves from the top
        always_ff @(posedge clk_dot4x) begin
            if (load_hit) begin
                shreg_q <= {shreg_q[`SPR_DATA_BITS-`SPR_BYTE_BITS-1:0], load_i.data};
            end else if ((start || run) && shift_now) begin
                shreg_q <= {shreg_q[`SPR_DATA_BITS-2:0], 1'b0};
            end
        end

        assign pix_o[n] = pix_q;
    end

endmodule

// File: m2m_detect.sv
`timescale 1ns/1ns

`include "sprite_defines.svh"

module m2m_detect (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  sprite_pkg::spr_pix_vec_t pix_i,
    output sprite_pkg::spr_mask_t    hit_o
);

    sprite_pkg::spr_mask_t upper;
    logic                  multi;

    // only the upper pixel bit counts as a solid dot for sprite overlap
    always_comb begin
        for (int n = 0; n < `SPR_NUM; n++) begin
            upper[n] = pix_i[n][`SPR_PIX_BITS-1];
        end
    end

    // clearing the lowest set bit leaves something only when two or more are set
    assign multi = (upper & (upper - 1'b1)) != '0;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            hit_o <= '0;
        end else begin
            hit_o <= multi ? upper : '0;
        end
    end

endmodule

// File: m2d_detect.sv
`timescale 1ns/1ns

`include "sprite_defines.svh"

module m2d_detect (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  sprite_pkg::spr_pix_vec_t pix_i,
    input  sprite_pkg::spr_mask_t    mmc_i,
    input  sprite_pkg::beam_t        beam_i,
    output sprite_pkg::spr_mask_t    hit_o
);

    logic                  border_q;
    logic                  beam_ok_q;
    sprite_pkg::spr_mask_t opaque;

    // a multicolor sprite is opaque on any nonzero pair,
    // a single color one only where its upper bit is set
    always_comb begin
        for (int n = 0; n < `SPR_NUM; n++) begin
            if (mmc_i[n]) begin
                opaque[n] = pix_i[n] != '0;
            end else begin
                opaque[n] = pix_i[n][`SPR_PIX_BITS-1];
            end
        end
    end

    // the beam levels change together with the tick that loads the new pixel,
    // so the gate is registered on the same edge to stay paired with that pixel
    // the first border dot after a low stretch still collides, which is why
    // the previous border level takes part in the gate
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            border_q  <= 1'b0;
            beam_ok_q <= 1'b0;
            hit_o     <= '0;
        end else begin
            border_q  <= beam_i.border;
            beam_ok_q <= !beam_i.background && (!beam_i.border || !border_q);
            hit_o     <= beam_ok_q ? opaque : '0;
        end
    end

endmodule

// File: collision_regs.sv
`timescale 1ns/1ns

`include "sprite_defines.svh"

module collision_regs (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  sprite_pkg::spr_mask_t m2m_hit_i,
    input  sprite_pkg::spr_mask_t m2d_hit_i,
    input  logic                  m2m_clr_i,
    input  logic                  m2d_clr_i,
    input  logic                  immc_clr_i,
    input  logic                  imbc_clr_i,
    output sprite_pkg::spr_mask_t m2m_o,
    output sprite_pkg::spr_mask_t m2d_o,
    output logic                  immc_o,
    output logic                  imbc_o
);

    // channel 0 is sprite to sprite, channel 1 is sprite to data
    sprite_pkg::spr_mask_t hit [2];
    sprite_pkg::spr_mask_t regs_q [2];
    logic [1:0] reg_clr;
    logic [1:0] flag_clr;
    logic [1:0] trig_q;
    logic [1:0] flag_q;

    assign hit[0] = m2m_hit_i;
    assign hit[1] = m2d_hit_i;
    assign reg_clr = {m2d_clr_i, m2m_clr_i};
    assign flag_clr = {imbc_clr_i, immc_clr_i};

    for (genvar c = 0; c < 2; c++) begin : g_chan
        always_ff @(posedge clk_dot4x) begin
            if (rst) begin
                regs_q[c] <= '0;
                trig_q[c] <= 1'b0;
                flag_q[c] <= 1'b0;
            end else begin
                // acknowledging the flag leaves the register untouched
                if (flag_clr[c]) begin
                    flag_q[c] <= 1'b0;
                end
                // a register clear beats a hit arriving in the same cycle
                // and allows the flag to fire again on the next hit
                if (reg_clr[c]) begin
                    regs_q[c] <= '0;
                    trig_q[c] <= 1'b0;
                end else if (hit[c] != '0) begin
                    regs_q[c] <= regs_q[c] | hit[c];
                    if (!trig_q[c]) begin
                        trig_q[c] <= 1'b1;
                        flag_q[c] <= 1'b1;
                    end
                end
            end
        end
    end

    assign m2m_o  = regs_q[0];
    assign m2d_o  = regs_q[1];
    assign immc_o = flag_q[0];
    assign imbc_o = flag_q[1];

endmodule

// File: sprite_collide_top.sv
`timescale 1ns/1ns

`include "sprite_defines.svh"

module sprite_collide_top (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  sprite_pkg::spr_cfg_t     cfg_i,
    input  sprite_pkg::spr_load_t    load_i,
    input  sprite_pkg::beam_t        beam_i,
    input  logic                     m2m_clr_i,
    input  logic                     m2d_clr_i,
    input  logic                     immc_clr_i,
    input  logic                     imbc_clr_i,
    output sprite_pkg::spr_pix_vec_t sprite_pix_o,
    output sprite_pkg::spr_mask_t    m2m_o,
    output sprite_pkg::spr_mask_t    m2d_o,
    output logic                     immc_o,
    output logic                     imbc_o
);

    sprite_pkg::spr_pix_vec_t pix;
    sprite_pkg::spr_mask_t    m2m_hit;
    sprite_pkg::spr_mask_t    m2d_hit;

    sprite_shifter_bank u_shifter_bank (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .cfg_i     (cfg_i),
        .load_i    (load_i),
        .beam_i    (beam_i),
        .pix_o     (pix)
    );

    // both detectors look at the same pixel vector in parallel
    m2m_detect u_m2m_detect (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .pix_i     (pix),
        .hit_o     (m2m_hit)
    );

    m2d_detect u_m2d_detect (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .pix_i     (pix),
        .mmc_i     (cfg_i.mmc),
        .beam_i    (beam_i),
        .hit_o     (m2d_hit)
    );

    collision_regs u_collision_regs (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .m2m_hit_i  (m2m_hit),
        .m2d_hit_i  (m2d_hit),
        .m2m_clr_i  (m2m_clr_i),
        .m2d_clr_i  (m2d_clr_i),
        .immc_clr_i (immc_clr_i),
        .imbc_clr_i (imbc_clr_i),
        .m2m_o      (m2m_o),
        .m2d_o      (m2d_o),
        .immc_o     (immc_o),
        .imbc_o     (imbc_o)
    );

    assign sprite_pix_o = pix;

endmodule

// File: sprite_collide_assert.sv
`timescale 1ns/1ns

module sprite_collide_assert (
    input logic                     clk_dot4x,
    input logic                     rst,
    input sprite_pkg::beam_t        beam_i,
    input sprite_pkg::spr_pix_vec_t pix_i,
    input sprite_pkg::spr_mask_t    m2m_i,
    input sprite_pkg::spr_mask_t    m2d_i,
    input logic                     immc_i,
    input logic                     imbc_i
);

    // the testbench reads this count when the run ends
    int fail_count = 0;

    // both interrupt flags leave reset low
    flags_after_reset: assert property (@(posedge clk_dot4x) rst |=> !immc_i && !imbc_i)
        else begin
            $error("interrupt flag high right after reset");
            fail_count++;
        end

    // a flag only rises together with a set register bit
    immc_needs_m2m: assert property (@(posedge clk_dot4x) disable iff (rst)
        $rose(immc_i) |-> m2m_i != '0)
        else begin
            $error("immc_o rose with an empty m2m register");
            fail_count++;
        end

    imbc_needs_m2d: assert property (@(posedge clk_dot4x) disable iff (rst)
        $rose(imbc_i) |-> m2d_i != '0)
        else begin
            $error("imbc_o rose with an empty m2d register");
            fail_count++;
        end

    // pixels move only on the edge that carries a dot tick
    pix_on_tick: assert property (@(posedge clk_dot4x) disable iff (rst)
        !$stable(pix_i) |-> $past(beam_i.dot_tick))
        else begin
            $error("sprite pixels changed without a dot tick");
            fail_count++;
        end

endmodule

bind sprite_collide_top sprite_collide_assert u_assert (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .beam_i    (beam_i),
    .pix_i     (sprite_pix_o),
    .m2m_i     (m2m_o),
    .m2d_i     (m2d_o),
    .immc_i    (immc_o),
    .imbc_i    (imbc_o)
);

// File: tb_sprite_collide.sv
`timescale 1ns/1ns

`include "sprite_defines.svh"

module tb_sprite_collide;

    // six tests of roughly 500 dot ticks at 40 ns each, plus margin
    localparam int TEST_TICKS = 6 * 500;
    localparam int TIMEOUT_NS = TEST_TICKS * 40 + 80000;

    logic                     clk_dot4x;
    logic                     rst;
    sprite_pkg::spr_cfg_t     cfg;
    sprite_pkg::spr_load_t    load;
    sprite_pkg::beam_t        beam;
    logic                     m2m_clr;
    logic                     m2d_clr;
    logic                     immc_clr;
    logic                     imbc_clr;
    sprite_pkg::spr_pix_vec_t sprite_pix;
    sprite_pkg::spr_mask_t    m2m;
    sprite_pkg::spr_mask_t    m2d;
    logic                     immc;
    logic                     imbc;

    // expected state of every sprite and of the collision registers
    sprite_pkg::spr_state_e    m_state [`SPR_NUM];
    logic [`SPR_DATA_BITS-1:0] m_data [`SPR_NUM];
    int                        m_loads [`SPR_NUM];
    int                        m_off [`SPR_NUM];
    sprite_pkg::spr_pix_vec_t  exp_pix;
    sprite_pkg::spr_mask_t     exp_m2m_hit;
    sprite_pkg::spr_mask_t     exp_m2d_hit;
    sprite_pkg::spr_mask_t     exp_m2m;
    sprite_pkg::spr_mask_t     exp_m2d;
    logic                      exp_immc;
    logic                      exp_imbc;
    logic                      trig_m2m;
    logic                      trig_m2d;
    logic                      last_border;
    logic                      tick_ok;
    int unsigned               lcg_state = 40;
    string                     test_name = "reset";

    sprite_collide_top uut (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .cfg_i        (cfg),
        .load_i       (load),
        .beam_i       (beam),
        .m2m_clr_i    (m2m_clr),
        .m2d_clr_i    (m2d_clr),
        .immc_clr_i   (immc_clr),
        .imbc_clr_i   (imbc_clr),
        .sprite_pix_o (sprite_pix),
        .m2m_o        (m2m),
        .m2d_o        (m2d),
        .immc_o       (immc),
        .imbc_o       (imbc)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #5 clk_dot4x = ~clk_dot4x;
    end

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // expected pixel of one sprite at offset k from its x match
    function automatic sprite_pkg::spr_pix_t ref_pix(logic [`SPR_DATA_BITS-1:0] data,
                                                     logic xe, logic mc, int k);
        int s;
        int j;
        int p;
        s = xe ? 2 : 1;
        if (k < 0 || k >= `SPR_DATA_BITS * s) begin
            return '0;
        end
        j = k / s;
        if (mc) begin
            p = j / 2;
            return {data[`SPR_DATA_BITS-1-2*p], data[`SPR_DATA_BITS-2-2*p]};
        end
        return {data[`SPR_DATA_BITS-1-j], 1'b0};
    endfunction

    // sprites with a solid dot collide only when two or more show one
    function automatic sprite_pkg::spr_mask_t m2m_ref(sprite_pkg::spr_pix_vec_t pix);
        sprite_pkg::spr_mask_t up;
        int                    cnt;
        up = '0;
        cnt = 0;
        for (int n = 0; n < `SPR_NUM; n++) begin
            up[n] = pix[n][1];
            if (pix[n][1]) begin
                cnt++;
            end
        end
        return (cnt >= 2) ? up : '0;
    endfunction

    function automatic sprite_pkg::spr_mask_t m2d_ref(sprite_pkg::spr_pix_vec_t pix,
                                                      sprite_pkg::spr_mask_t mc, logic ok);
        sprite_pkg::spr_mask_t hit;
        for (int n = 0; n < `SPR_NUM; n++) begin
            hit[n] = ok && (mc[n] ? (pix[n] != '0) : pix[n][1]);
        end
        return hit;
    endfunction

    task automatic abort_run(string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_pix(string what, sprite_pkg::spr_pix_vec_t exp,
                             sprite_pkg::spr_pix_vec_t act);
        if (act !== exp) begin
            $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
            abort_run("pixel mismatch");
        end
    endtask

    task automatic check_mask(string what, sprite_pkg::spr_mask_t exp,
                              sprite_pkg::spr_mask_t act);
        if (act !== exp) begin
            $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
            abort_run("mask mismatch");
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("error %s: %s expected %b actual %b", test_name, what, exp, act);
            abort_run("flag mismatch");
        end
    endtask

    // the model only reads inputs driven 1 ns after the previous edge
    always @(posedge clk_dot4x) begin : ref_model
        logic load_ok;
        if (rst) begin
            for (int n = 0; n < `SPR_NUM; n++) begin
                m_state[n] = sprite_pkg::SPR_IDLE;
                m_loads[n] = 0;
                m_off[n] = 0;
            end
            exp_pix = '0;
            exp_m2m_hit = '0;
            exp_m2d_hit = '0;
            exp_m2m = '0;
            exp_m2d = '0;
            exp_immc = 1'b0;
            exp_imbc = 1'b0;
            trig_m2m = 1'b0;
            trig_m2d = 1'b0;
            last_border = 1'b0;
            tick_ok = 1'b0;
        end else begin
            // registers take last cycle's hits, a clear wins over a hit
            if (immc_clr) begin
                exp_immc = 1'b0;
            end
            if (imbc_clr) begin
                exp_imbc = 1'b0;
            end
            if (m2m_clr) begin
                exp_m2m = '0;
                trig_m2m = 1'b0;
            end else if (exp_m2m_hit != '0) begin
                exp_m2m = exp_m2m | exp_m2m_hit;
                exp_immc = exp_immc || !trig_m2m;
                trig_m2m = 1'b1;
            end
            if (m2d_clr) begin
                exp_m2d = '0;
                trig_m2d = 1'b0;
            end else if (exp_m2d_hit != '0) begin
                exp_m2d = exp_m2d | exp_m2d_hit;
                exp_imbc = exp_imbc || !trig_m2d;
                trig_m2d = 1'b1;
            end
            // hit vectors follow the pixels one cycle later
            exp_m2m_hit = m2m_ref(exp_pix);
            exp_m2d_hit = m2d_ref(exp_pix, cfg.mmc, tick_ok);
            // a load only counts on an enabled sprite that is not armed yet
            load_ok = load.valid && cfg.en[load.idx]
                      && (m_state[load.idx] == sprite_pkg::SPR_IDLE
                          || m_state[load.idx] == sprite_pkg::SPR_LOADING);
            if (beam.dot_tick) begin
                // a border that has just risen still lets the pixel collide
                tick_ok = !beam.background && (!beam.border || !last_border);
                last_border = beam.border;
                for (int n = 0; n < `SPR_NUM; n++) begin
                    if (m_state[n] == sprite_pkg::SPR_ARMED && beam.xpos == cfg.x[n]) begin
                        m_state[n] = sprite_pkg::SPR_SHIFTING;
                        m_off[n] = -1;
                    end
                    if (m_state[n] == sprite_pkg::SPR_SHIFTING) begin
                        m_off[n]++;
                        exp_pix[n] = ref_pix(m_data[n], cfg.xe[n], cfg.mmc[n], m_off[n]);
                        if (m_off[n] >= `SPR_DATA_BITS * (cfg.xe[n] ? 2 : 1)) begin
                            m_state[n] = sprite_pkg::SPR_IDLE;
                        end
                    end
                end
            end
            if (load_ok) begin
                m_data[load.idx] = {m_data[load.idx][`SPR_DATA_BITS-`SPR_BYTE_BITS-1:0],
                                    load.data};
                if (m_loads[load.idx] == `SPR_LOADS - 1) begin
                    m_loads[load.idx] = 0;
                    m_state[load.idx] = sprite_pkg::SPR_ARMED;
                end else begin
                    m_loads[load.idx]++;
                    m_state[load.idx] = sprite_pkg::SPR_LOADING;
                end
            end
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk_dot4x) begin
        if (!rst) begin
            check_pix("sprite_pix_o", exp_pix, sprite_pix);
            check_mask("m2m_o", exp_m2m, m2m);
            check_mask("m2d_o", exp_m2d, m2d);
            check_flag("immc_o", exp_immc, immc);
            check_flag("imbc_o", exp_imbc, imbc);
        end
        // a bound assertion that fired ends the run right away
        if (uut.u_assert.fail_count != 0) begin
            $display("bound assertions failed %0d times", uut.u_assert.fail_count);
            abort_run("assertion failure");
        end
    end

    task automatic step_cycle();
        @(posedge clk_dot4x);
        #1;
    endtask

    task automatic load_byte(int idx, logic [7:0] data);
        load.valid = 1'b1;
        load.idx = sprite_pkg::spr_idx_t'(idx);
        load.data = data;
        step_cycle();
        load.valid = 1'b0;
    endtask

    // or_mask forces bits of the first byte, which shows first
    task automatic load_sprite(int idx, logic [7:0] or_mask);
        for (int b = 0; b < `SPR_LOADS; b++) begin
            load_byte(idx, lcg_byte() | (b == 0 ? or_mask : 8'h00));
        end
    endtask

    task automatic set_sprite(int n, logic en, logic xe, logic mmc, int x);
        cfg.en[n] = en;
        cfg.xe[n] = xe;
        cfg.mmc[n] = mmc;
        cfg.x[n] = sprite_pkg::spr_x_t'(x);
    endtask

    // one dot lasts four clk_dot4x cycles, the beam levels hold across it
    task automatic dot_tick(int xpos, logic bg, logic border);
        beam.dot_tick = 1'b1;
        beam.xpos = sprite_pkg::spr_x_t'(xpos);
        beam.background = bg;
        beam.border = border;
        step_cycle();
        beam.dot_tick = 1'b0;
        repeat (3) step_cycle();
    endtask

    task automatic run_line(int ticks);
        for (int x = 0; x < ticks; x++) begin
            dot_tick(x, 1'b0, 1'b0);
        end
    endtask

    task automatic pulse_clears(logic m2m_c, logic m2d_c, logic immc_c, logic imbc_c);
        m2m_clr = m2m_c;
        m2d_clr = m2d_c;
        immc_clr = immc_c;
        imbc_clr = imbc_c;
        step_cycle();
        m2m_clr = 1'b0;
        m2d_clr = 1'b0;
        immc_clr = 1'b0;
        imbc_clr = 1'b0;
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests finished");
        abort_run("timeout");
    end

    initial begin : main
        rst = 1'b1;
        cfg = '0;
        load = '0;
        beam = '0;
        m2m_clr = 1'b0;
        m2d_clr = 1'b0;
        immc_clr = 1'b0;
        imbc_clr = 1'b0;
        repeat (10) @(posedge clk_dot4x);
        #1;
        rst = 1'b0;

        test_name = "single_color";
        set_sprite(0, 1'b1, 1'b0, 1'b0, 20);
        load_sprite(0, 8'h00);
        run_line(60);

        // sprite 0 is idle again and must not restart without new loads
        test_name = "disabled";
        set_sprite(5, 1'b0, 1'b0, 1'b0, 8);
        load_sprite(5, 8'hff);
        run_line(40);
        pulse_clears(1'b1, 1'b1, 1'b1, 1'b1);

        test_name = "xexp_mc";
        set_sprite(1, 1'b1, 1'b1, 1'b0, 5);
        set_sprite(2, 1'b1, 1'b0, 1'b1, 40);
        set_sprite(3, 1'b1, 1'b1, 1'b1, 70);
        load_sprite(1, 8'h00);
        load_sprite(2, 8'h00);
        load_sprite(3, 8'h00);
        run_line(130);
        pulse_clears(1'b1, 1'b1, 1'b1, 1'b1);

        // both sprites show a solid dot at offset 0 on the same x
        test_name = "m2m";
        set_sprite(4, 1'b1, 1'b0, 1'b0, 10);
        set_sprite(6, 1'b1, 1'b0, 1'b1, 10);
        load_sprite(4, 8'h80);
        load_sprite(6, 8'h80);
        run_line(40);
        check_flag("immc_o raised", 1'b1, immc);
        check_flag("m2m_o sprite 4", 1'b1, m2m[4]);
        check_flag("m2m_o sprite 6", 1'b1, m2m[6]);

        test_name = "clear";
        pulse_clears(1'b0, 1'b0, 1'b1, 1'b0);
        check_flag("immc_o acknowledged", 1'b0, immc);
        load_sprite(4, 8'h80);
        load_sprite(6, 8'h80);
        run_line(40);
        check_flag("immc_o without register clear", 1'b0, immc);
        pulse_clears(1'b1, 1'b1, 1'b0, 1'b0);
        check_mask("m2m_o cleared", '0, m2m);
        check_mask("m2d_o cleared", '0, m2d);
        load_sprite(4, 8'h80);
        load_sprite(6, 8'h80);
        run_line(40);
        check_flag("immc_o after register clear", 1'b1, immc);
        pulse_clears(1'b1, 1'b1, 1'b1, 1'b1);

        // background hides offsets 0 and 1, border rises at offset 2
        test_name = "m2d_border";
        cfg = '0;
        set_sprite(7, 1'b1, 1'b0, 1'b0, 10);
        load_sprite(7, 8'hff);
        for (int x = 0; x < 40; x++) begin
            dot_tick(x, x < 12, x >= 12);
        end
        check_mask("m2d_o at border edge", 8'h80, m2d);
        pulse_clears(1'b1, 1'b1, 1'b1, 1'b1);
        load_sprite(7, 8'hff);
        for (int x = 0; x < 40; x++) begin
            dot_tick(x, 1'b0, 1'b1);
        end
        check_mask("m2d_o under held border", '0, m2d);

        if (uut.u_assert.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", uut.u_assert.fail_count);
            abort_run("assertion failures");
        end
    end

endmodule

// File: sprite_collide.f
+incdir+.
sprite_pkg.sv
sprite_shifter_bank.sv
m2m_detect.sv
m2d_detect.sv
collision_regs.sv
sprite_collide_top.sv
sprite_collide_assert.sv
tb_sprite_collide.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sprite_collide.f \
    --top-module tb_sprite_collide -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# a raised error limit lets the testbench count assertion failures itself
./obj_dir/tb_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation finished cleanly"
exit 0
